//--- src/acc_pkg.sv
package acc_pkg;

    // ======================================================================
    // Datapath widths
    // ======================================================================

    // Accumulator and partial-sum width
    localparam int ACC_W = 32;
    // Quantized output byte
    localparam int OUT_W = 8;
    // Accumulators per read word
    localparam int LANES = 8;
    // One read word carries LANES bytes
    localparam int WORD_W = LANES * OUT_W;

    // Q16.16 scale factor
    localparam int SCALE_W = 32;
    localparam int FRAC_BITS = 16;

    // INT8 saturation bounds
    localparam int SAT_MAX = 127;
    localparam int SAT_MIN = -128;

    // ======================================================================
    // Control types
    // ======================================================================

    // One opcode per command strobe
    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_CLEAR = 2'd1,
        OP_ACCUM = 2'd2,
        OP_DONE  = 2'd3
    } acc_op_e;

    // Tile tracking, open between CLEAR and DONE
    typedef enum logic {
        TILE_IDLE = 1'b0,
        TILE_OPEN = 1'b1
    } tile_state_e;

    // Command strobe, 3 bits
    typedef struct packed {
        logic    valid;
        acc_op_e op;
    } acc_cmd_t;

    // Readout quantization setup, 33 bits
    typedef struct packed {
        logic               relu_en;
        logic [SCALE_W-1:0] scale;
    } quant_cfg_t;

endpackage

//--- src/psum_intake.sv
`timescale 1ns/10ps

module psum_intake
    import acc_pkg::*;
#(
    parameter int N_ROWS = 4,
    parameter int N_COLS = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  acc_cmd_t                         cmd,
    input  logic [N_ROWS*N_COLS*ACC_W-1:0]   psum,
    output acc_cmd_t                         cmd_q,
    output logic [N_ROWS*N_COLS*ACC_W-1:0]   psum_q,
    output logic                             busy
);

    tile_state_e tile_state;

    // Command register, one cycle ahead of the banks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q <= '0;
        end else begin
            cmd_q <= cmd;
        end
    end

    // Partial sums only matter for ACCUM, hold them otherwise
    always_ff @(posedge clk) begin
        if (cmd.valid && (cmd.op == OP_ACCUM)) begin
            psum_q <= psum;
        end
    end

    // ======================================================================
    // Tile state
    // ======================================================================

    // Follows the registered command so busy moves with bank_sel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_state <= TILE_IDLE;
        end else if (cmd_q.valid) begin
            case (cmd_q.op)
                OP_CLEAR: tile_state <= TILE_OPEN;
                OP_DONE:  tile_state <= TILE_IDLE;
                default:  tile_state <= tile_state;
            endcase
        end
    end

    assign busy = (tile_state == TILE_OPEN);

    // A tile must be opened by CLEAR before any partial sum lands
    a_accum_needs_open_tile: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_q.valid && (cmd_q.op == OP_ACCUM)) |-> (tile_state == TILE_OPEN))
        else $error("ACCUM command with no open tile");

endmodule

//--- src/acc_banks.sv
`timescale 1ns/10ps

module acc_banks
    import acc_pkg::*;
#(
    parameter int N_ROWS = 4,
    parameter int N_COLS = 4,
    parameter int ADDR_W = 1
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  acc_cmd_t                         cmd_q,
    input  logic [N_ROWS*N_COLS*ACC_W-1:0]   psum_q,
    input  logic                             rd_en,
    input  logic [ADDR_W-1:0]                rd_addr,
    output logic [LANES*ACC_W-1:0]           word_acc,
    output logic                             word_valid,
    output logic                             dma_ready,
    output logic                             bank_sel
);

    localparam int N_ACC = N_ROWS * N_COLS;
    localparam int N_WORDS = N_ACC / LANES;

    // Two ping-pong banks, bank_sel picks the accumulating one
    logic signed [ACC_W-1:0] bank [2][N_ACC];

    // Per-bank ready flags, set on DONE, cleared by the first read
    logic [1:0] ready;

    logic inactive;
    logic do_clear;
    logic do_accum;
    logic do_done;
    int   rd_base;

    assign inactive = ~bank_sel;
    assign do_clear = cmd_q.valid && (cmd_q.op == OP_CLEAR);
    assign do_accum = cmd_q.valid && (cmd_q.op == OP_ACCUM);
    assign do_done  = cmd_q.valid && (cmd_q.op == OP_DONE);

    // First accumulator of the addressed word
    assign rd_base = int'(rd_addr) * LANES;

    // DMA sees only the finished bank
    assign dma_ready = ready[inactive];

    // ======================================================================
    // Accumulate into the active bank
    // ======================================================================

    // All lanes in parallel, two's-complement wrap on overflow
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_ACC; i++) begin
            if (do_clear) begin
                bank[bank_sel][i] <= '0;
            end else if (do_accum) begin
                bank[bank_sel][i] <= bank[bank_sel][i]
                                   + $signed(psum_q[i*ACC_W +: ACC_W]);
            end
        end
    end

    // Bank swap and ready tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_sel <= 1'b0;
            ready    <= '0;
        end else begin
            if (rd_en) begin
                ready[inactive] <= 1'b0;
            end
            // Finished bank becomes the drain side
            if (do_done) begin
                ready[bank_sel] <= 1'b1;
                bank_sel        <= ~bank_sel;
            end
        end
    end

    // ======================================================================
    // Word read from the inactive bank
    // ======================================================================

    // Lane k of word a is accumulator a*LANES+k
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int k = 0; k < LANES; k++) begin
                word_acc[k*ACC_W +: ACC_W] <= bank[inactive][rd_base + k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= rd_en;
        end
    end

    // DMA must stay inside the tile
    a_rd_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> (int'(rd_addr) < N_WORDS))
        else $error("rd_addr beyond last word of the tile");

    // A swap under a read would change the source bank mid-drain
    a_no_read_on_swap: assert property (@(posedge clk) disable iff (!rst_n)
        not (rd_en && do_done))
        else $error("rd_en in the same cycle as a DONE swap");

endmodule

//--- src/quant_readout.sv
`timescale 1ns/10ps

module quant_readout
    import acc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [LANES*ACC_W-1:0]   word_acc,
    input  logic                     word_valid,
    input  quant_cfg_t               qcfg,
    output logic [WORD_W-1:0]        rd_data,
    output logic                     rd_valid
);

    // ======================================================================
    // Per-lane quantizer
    // ======================================================================

    // ReLU, Q16.16 scale, INT8 clamp
    function automatic logic [OUT_W-1:0] quantize(
        input logic signed [ACC_W-1:0] acc,
        input quant_cfg_t              cfg
    );
        logic signed [ACC_W-1:0]         relu_val;
        logic signed [ACC_W+SCALE_W:0]   prod;
        logic signed [ACC_W+SCALE_W:0]   shifted;

        // Negative sums drop to zero under ReLU
        if (cfg.relu_en && (acc < 0)) begin
            relu_val = '0;
        end else begin
            relu_val = acc;
        end

        // Scale is unsigned, zero bit on top keeps the product signed
        prod    = relu_val * $signed({1'b0, cfg.scale});
        shifted = prod >>> FRAC_BITS;

        // Clamp to INT8
        if (shifted > SAT_MAX) begin
            return OUT_W'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            return OUT_W'(SAT_MIN);
        end
        return shifted[OUT_W-1:0];
    endfunction

    logic [WORD_W-1:0] q_word;

    // Byte k carries lane k
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            q_word[k*OUT_W +: OUT_W] = quantize(word_acc[k*ACC_W +: ACC_W], qcfg);
        end
    end

    // ======================================================================
    // Output register
    // ======================================================================

    always_ff @(posedge clk) begin
        if (word_valid) begin
            rd_data <= q_word;
        end
    end

    // One-cycle strobe per word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= word_valid;
        end
    end

endmodule

//--- src/output_accumulator.sv
`timescale 1ns/10ps

module output_accumulator
    import acc_pkg::*;
#(
    parameter int N_ROWS = 4,
    parameter int N_COLS = 4,
    parameter int ADDR_W = 1
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  acc_cmd_t                         cmd,
    input  logic [N_ROWS*N_COLS*ACC_W-1:0]   psum,
    input  quant_cfg_t                       qcfg,
    input  logic                             rd_en,
    input  logic [ADDR_W-1:0]                rd_addr,
    output logic [WORD_W-1:0]                rd_data,
    output logic                             rd_valid,
    output logic                             dma_ready,
    output logic                             bank_sel,
    output logic                             busy
);

    // Intake to banks
    acc_cmd_t                           cmd_q;
    logic [N_ROWS*N_COLS*ACC_W-1:0]     psum_q;

    // Banks to readout
    logic [LANES*ACC_W-1:0]             word_acc;
    logic                               word_valid;

    // ======================================================================
    // Command intake, tile tracking
    // ======================================================================
    psum_intake #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS)
    ) psum_intake_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (cmd),
        .psum   (psum),
        .cmd_q  (cmd_q),
        .psum_q (psum_q),
        .busy   (busy)
    );

    // Ping-pong banks and word fetch
    acc_banks #(
        .N_ROWS (N_ROWS),
        .N_COLS (N_COLS),
        .ADDR_W (ADDR_W)
    ) acc_banks_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_q      (cmd_q),
        .psum_q     (psum_q),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .word_acc   (word_acc),
        .word_valid (word_valid),
        .dma_ready  (dma_ready),
        .bank_sel   (bank_sel)
    );

    // Quantize and pack to bytes
    quant_readout quant_readout_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_acc   (word_acc),
        .word_valid (word_valid),
        .qcfg       (qcfg),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- tb/tb_output_accumulator.sv
`timescale 1ns/10ps

module tb_output_accumulator
    import acc_pkg::*;
();

    localparam int N_ACC   = 16;
    localparam int N_WORDS = N_ACC / LANES;
    localparam int ADDR_W  = 1;

    logic                   clk;
    logic                   rst_n;
    acc_cmd_t               cmd;
    logic [N_ACC*ACC_W-1:0] psum;
    quant_cfg_t             qcfg;
    logic                   rd_en;
    logic [ADDR_W-1:0]      rd_addr;
    logic [WORD_W-1:0]      rd_data;
    logic                   rd_valid;
    logic                   dma_ready;
    logic                   bank_sel;
    logic                   busy;

    // Reference model state
    logic signed [ACC_W-1:0] m_bank [2][N_ACC];
    logic                    m_sel;
    logic [1:0]              m_ready;

    // Expected read words and the cycle each is due
    logic [WORD_W-1:0] exp_q [$];
    int                due_q [$];
    int                cyc = 0;
    int                seed = 32'h9eb2_0685;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) clock_gen_i (.clk(clk), .rst_n(rst_n));

    output_accumulator #(
        .N_ROWS (4),
        .N_COLS (4),
        .ADDR_W (ADDR_W)
    ) output_accumulator_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .psum      (psum),
        .qcfg      (qcfg),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .dma_ready (dma_ready),
        .bank_sel  (bank_sel),
        .busy      (busy)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        assert (got === want)
            else fail_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                    $time, name, got, want));
    endtask

    // Quantize one lane by ReLU and the unsigned Q16.16 scale and clamp it to INT8
    function automatic logic [OUT_W-1:0] quant_lane(input int acc, input quant_cfg_t cfg);
        longint v;
        longint s;
        v = acc;
        if (cfg.relu_en && (v < 0)) begin
            v = 0;
        end
        s = longint'({32'b0, cfg.scale});
        v = (v * s) >>> FRAC_BITS;
        if (v > SAT_MAX) v = SAT_MAX;
        if (v < SAT_MIN) v = SAT_MIN;
        return v[OUT_W-1:0];
    endfunction

    // Drives one stimulus cycle and updates the model at once
    task automatic drive_cycle(input acc_op_e op, input bit rd, input int addr);
        logic [WORD_W-1:0] w;
        logic              inact;
        int                lane;
        @(posedge clk);
        #1;
        cmd.valid = (op != OP_NOP);
        cmd.op    = op;
        rd_en     = rd;
        rd_addr   = rd ? ADDR_W'(addr) : '0;
        if (op == OP_CLEAR) begin
            for (int i = 0; i < N_ACC; i++) m_bank[m_sel][i] = '0;
        end
        if (op == OP_ACCUM) begin
            for (int i = 0; i < N_ACC; i++) begin
                // About half the lanes get full-range values and the rest small ones
                if ($random(seed) & 1) lane = $random(seed);
                else lane = $random(seed) % 100;
                psum[i*ACC_W +: ACC_W] = lane;
                m_bank[m_sel][i] = m_bank[m_sel][i] + lane;
            end
        end
        if (op == OP_DONE) begin
            m_ready[m_sel] = 1'b1;
            m_sel = ~m_sel;
        end
        if (rd) begin
            inact = ~m_sel;
            for (int k = 0; k < LANES; k++) begin
                w[k*OUT_W +: OUT_W] = quant_lane(m_bank[inact][addr*LANES + k], qcfg);
            end
            exp_q.push_back(w);
            due_q.push_back(cyc + 2);
            m_ready[inact] = 1'b0;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (dma_ready !== 1'b1) begin
            @(posedge clk);
            #1;
            n++;
            assert (n < 20) else fail_run("Timed out waiting for dma_ready after DONE");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            n++;
            assert (n < 10) else fail_run("Timed out waiting for rd_valid of issued reads");
        end
    endtask

    // ======================================================================
    // Tile flow and readback
    // ======================================================================

    // CLEAR then random ACCUMs then DONE
    // With drain set the finished bank is read during the new tile
    task automatic run_tile(input bit drain);
        int n;
        n = 2 + ($random(seed) & 3);
        drive_cycle(OP_CLEAR, drain, 0);
        for (int c = 1; c <= n; c++) begin
            drive_cycle(OP_ACCUM, drain && (c < N_WORDS), c);
        end
        check_flag("busy", busy, 1'b1);
        check_flag("dma_ready", dma_ready, m_ready[~m_sel]);
        drive_cycle(OP_DONE, 1'b0, 0);
        drive_cycle(OP_NOP, 1'b0, 0);
        wait_ready();
        check_flag("bank_sel", bank_sel, m_sel);
        check_flag("busy", busy, 1'b0);
    endtask

    // Back-to-back reads of every word of the finished bank
    task automatic read_all();
        for (int w = 0; w < N_WORDS; w++) begin
            drive_cycle(OP_NOP, 1'b1, w);
            // Ready drops once the first rd_en is sampled
            if (w > 0) begin
                check_flag("dma_ready", dma_ready, m_ready[~m_sel]);
            end
        end
        drive_cycle(OP_NOP, 1'b0, 0);
        wait_drained();
        check_flag("dma_ready", dma_ready, m_ready[~m_sel]);
    endtask

    // Read results land in order two cycles after rd_en
    always @(negedge clk) begin
        if (rst_n && rd_valid) begin
            assert (exp_q.size() != 0) else fail_run("rd_valid rose with no read issued");
            assert (cyc == due_q[0])
                else fail_run($sformatf("CHECK FAILED at %0t: rd_valid at cycle %0d, due %0d",
                                        $time, cyc, due_q[0]));
            assert (rd_data === exp_q[0])
                else fail_run($sformatf("CHECK FAILED at %0t: rd_data is %h, expected %h",
                                        $time, rd_data, exp_q[0]));
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        int n;
        cmd     = '0;
        psum    = '0;
        qcfg    = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        m_sel   = 1'b0;
        m_ready = '0;
        n       = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            assert (n < 20) else fail_run("Timed out waiting for reset release");
        end
        @(posedge clk);
        #1;
        check_flag("bank_sel", bank_sel, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("dma_ready", dma_ready, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);

        // Scale of 1.0 with relu off and then on
        qcfg.relu_en = 1'b0;
        qcfg.scale   = 32'h0001_0000;
        run_tile(1'b0);
        read_all();
        qcfg.relu_en = 1'b1;
        run_tile(1'b0);
        read_all();

        // Two random scales below 1.0 and then two above it up to about 4.0
        for (int t = 0; t < 4; t++) begin
            qcfg.relu_en = 1'b0;
            if (t < 2) begin
                qcfg.scale = $random(seed) & 32'h0000_ffff;
            end else begin
                qcfg.scale = 32'h0001_0001 + ($random(seed) & 32'h0002_ffff);
            end
            run_tile(1'b0);
            read_all();
        end

        // Ping-pong drains one bank while the next tile fills the other
        qcfg.scale = 32'h0001_0000;
        run_tile(1'b0);
        run_tile(1'b1);
        read_all();

        if (exp_q.size() == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run("Reads still outstanding at end of run");
        end
    end

endmodule

//--- all.f
src/acc_pkg.sv
src/psum_intake.sv
src/acc_banks.sv
src/quant_readout.sv
src/output_accumulator.sv
tb/tb_clock_gen.sv
tb/tb_output_accumulator.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the output accumulator testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_output_accumulator -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
